//--- verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int numGpr = 16;

    // alu function select
    typedef enum logic [4:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opShr,
        opShra,
        opShl,
        opRor,
        opRol,
        opMul,
        opDiv,
        opNeg,
        opNot
    } aluOp;

    // bus source codes, lower code wins when strobes overlap
    typedef enum logic [4:0] {
        srcR0, srcR1, srcR2, srcR3,
        srcR4, srcR5, srcR6, srcR7,
        srcR8, srcR9, srcR10, srcR11,
        srcR12, srcR13, srcR14, srcR15,
        srcHi,
        srcLo,
        srcZHigh,
        srcZLow,
        srcPc,
        srcMdr,
        srcInPort,
        srcConst,
        srcNone
    } busSrc;

endpackage

`default_nettype wire

//--- verilog/gprFile.sv
`timescale 1ns/1ps
`default_nettype none

module gprFile #(
    parameter int dataWidth = 32
) (
    input  wire                                            clk,
    input  wire                                            rst,
    input  wire  [cpuPkg::numGpr-1:0]                      load,
    input  wire  [dataWidth-1:0]                           busData,
    output logic [cpuPkg::numGpr-1:0][dataWidth-1:0]       regs
);

    localparam int numGpr = cpuPkg::numGpr;

    // R1 and up are real flops
    logic [numGpr-1:1][dataWidth-1:0] gpr;

    always_ff @(posedge clk) begin
        if (rst) begin
            gpr <= '0;
        end else begin
            for (int i = 1; i < numGpr; i++) begin
                if (load[i]) begin
                    gpr[i] <= busData;
                end
            end
        end
    end

    // R0 is hardwired, load[0] has nothing to write
    assign regs = {gpr, {dataWidth{1'b0}}};

endmodule

`default_nettype wire

//--- verilog/busMux.sv
`timescale 1ns/1ps
`default_nettype none

module busMux #(
    parameter int dataWidth = 32
) (
    input  wire  [cpuPkg::numGpr-1:0]                gprDrive,
    input  wire                                      hiOut,
    input  wire                                      loOut,
    input  wire                                      zHighOut,
    input  wire                                      zLowOut,
    input  wire                                      pcOut,
    input  wire                                      mdrOut,
    input  wire                                      inPortOut,
    input  wire                                      cOut,
    input  wire  [cpuPkg::numGpr-1:0][dataWidth-1:0] gprVals,
    input  wire  [dataWidth-1:0]                     hiVal,
    input  wire  [dataWidth-1:0]                     loVal,
    input  wire  [dataWidth-1:0]                     zHighVal,
    input  wire  [dataWidth-1:0]                     zLowVal,
    input  wire  [dataWidth-1:0]                     pcVal,
    input  wire  [dataWidth-1:0]                     mdrVal,
    input  wire  [dataWidth-1:0]                     inPortVal,
    input  wire  [dataWidth-1:0]                     cData,
    output logic [dataWidth-1:0]                     busData
);

    localparam int numSrc = cpuPkg::numGpr + 8;

    logic [numSrc-1:0]    drive;
    cpuPkg::busSrc        src;
    logic [dataWidth-1:0] constExt;

    // bit index equals the source code
    assign drive = {cOut, inPortOut, mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut, gprDrive};

    assign constExt = {{(dataWidth-19){cData[18]}}, cData[18:0]}; // 19-bit immediate

    // priority encoder, scan downward so the lowest code is left standing
    always_comb begin
        src = cpuPkg::srcNone;
        for (int i = numSrc - 1; i >= 0; i--) begin
            if (drive[i]) begin
                src = cpuPkg::busSrc'(i[4:0]);
            end
        end
    end

    always_comb begin
        case (src)
            cpuPkg::srcHi:     busData = hiVal;
            cpuPkg::srcLo:     busData = loVal;
            cpuPkg::srcZHigh:  busData = zHighVal;
            cpuPkg::srcZLow:   busData = zLowVal;
            cpuPkg::srcPc:     busData = pcVal;
            cpuPkg::srcMdr:    busData = mdrVal;
            cpuPkg::srcInPort: busData = inPortVal;
            cpuPkg::srcConst:  busData = constExt;
            cpuPkg::srcNone:   busData = '0;
            default:           busData = gprVals[src[3:0]]; // R0..R15
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
    parameter int dataWidth = 32
) (
    input  wire  [dataWidth-1:0]   a,
    input  wire  [dataWidth-1:0]   b,
    input  var   cpuPkg::aluOp     opcode,
    output logic [2*dataWidth-1:0] result
);

    localparam int shW = $clog2(dataWidth);

    logic [shW-1:0]                sh;
    logic [2*dataWidth-1:0]        dbl;
    logic [2*dataWidth-1:0]        rotR;
    logic [2*dataWidth-1:0]        rotL;
    logic signed [2*dataWidth-1:0] aExt;
    logic signed [2*dataWidth-1:0] bExt;
    logic signed [2*dataWidth-1:0] prod;
    logic [dataWidth-1:0]          quot;
    logic [dataWidth-1:0]          rem;
    logic                          divOvf;

    assign sh = b[shW-1:0]; // low bits of B only

    // rotates via a doubled copy of A
    assign dbl  = {a, a};
    assign rotR = dbl >> sh;
    assign rotL = dbl << sh;

    assign aExt = {{dataWidth{a[dataWidth-1]}}, a};
    assign bExt = {{dataWidth{b[dataWidth-1]}}, b};
    assign prod = aExt * bExt;

    // most negative / -1 does not fit, keep the dividend
    assign divOvf = (a == {1'b1, {(dataWidth-1){1'b0}}}) && (b == '1);

    always_comb begin
        if (b == '0) begin
            quot = '1;
            rem  = a;
        end else if (divOvf) begin
            quot = a;
            rem  = '0;
        end else begin
            quot = $signed(a) / $signed(b);
            rem  = $signed(a) % $signed(b);
        end
    end

    always_comb begin
        result = '0;
        case (opcode)
            cpuPkg::opAdd:  result[dataWidth-1:0] = a + b;
            cpuPkg::opSub:  result[dataWidth-1:0] = a - b;
            cpuPkg::opAnd:  result[dataWidth-1:0] = a & b;
            cpuPkg::opOr:   result[dataWidth-1:0] = a | b;
            cpuPkg::opShr:  result[dataWidth-1:0] = a >> sh;
            cpuPkg::opShra: result[dataWidth-1:0] = $signed(a) >>> sh;
            cpuPkg::opShl:  result[dataWidth-1:0] = a << sh;
            cpuPkg::opRor:  result[dataWidth-1:0] = rotR[dataWidth-1:0];
            cpuPkg::opRol:  result[dataWidth-1:0] = rotL[2*dataWidth-1:dataWidth];
            cpuPkg::opMul:  result = prod;
            cpuPkg::opDiv:  result = {rem, quot}; // remainder high, quotient low
            cpuPkg::opNeg:  result[dataWidth-1:0] = -b; // unary ops take the bus
            cpuPkg::opNot:  result[dataWidth-1:0] = ~b;
            default:        result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/memInterface.sv
`timescale 1ns/1ps
`default_nettype none

module memInterface #(
    parameter int dataWidth = 32
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  marIn,
    input  wire                  mdrIn,
    input  wire                  read,
    input  wire  [dataWidth-1:0] busData,
    input  wire  [dataWidth-1:0] mdataIn,
    input  wire  [dataWidth-1:0] inPortData,
    output logic [dataWidth-1:0] marAddr,
    output logic [dataWidth-1:0] mdrVal,
    output logic [dataWidth-1:0] inPortVal
);

    always_ff @(posedge clk) begin
        if (rst) begin
            marAddr   <= '0;
            mdrVal    <= '0;
            inPortVal <= '0;
        end else begin
            if (marIn) begin
                marAddr <= busData; // address goes straight out
            end
            if (mdrIn) begin
                mdrVal <= read ? mdataIn : busData;
            end
            inPortVal <= inPortData; // free-running sample
        end
    end

endmodule

`default_nettype wire

//--- verilog/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath #(
    parameter int dataWidth = 32
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire  [cpuPkg::numGpr-1:0]  gprIn,
    input  wire  [cpuPkg::numGpr-1:0]  gprOut,
    input  wire                        hiIn,
    input  wire                        loIn,
    input  wire                        zIn,
    input  wire                        pcIn,
    input  wire                        incPc,
    input  wire                        marIn,
    input  wire                        mdrIn,
    input  wire                        yIn,
    input  wire                        read,
    input  wire                        hiOut,
    input  wire                        loOut,
    input  wire                        zHighOut,
    input  wire                        zLowOut,
    input  wire                        pcOut,
    input  wire                        mdrOut,
    input  wire                        inPortOut,
    input  wire                        cOut,
    input  wire  [dataWidth-1:0]       cData,
    input  var   cpuPkg::aluOp         opcode,
    input  wire  [dataWidth-1:0]       mdataIn,
    input  wire  [dataWidth-1:0]       inPortData,
    output logic [dataWidth-1:0]       busData,
    output logic [dataWidth-1:0]       marAddr
);

    logic [cpuPkg::numGpr-1:0][dataWidth-1:0] gprVals;
    logic [dataWidth-1:0]   hi, lo, pc, y, zHigh, zLow;
    logic [dataWidth-1:0]   mdrVal;
    logic [dataWidth-1:0]   inPortVal;
    logic [2*dataWidth-1:0] aluResult;

    gprFile #(.dataWidth(dataWidth)) gpr0 (
        .clk     (clk),
        .rst     (rst),
        .load    (gprIn),
        .busData (busData),
        .regs    (gprVals)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            hi    <= '0;
            lo    <= '0;
            pc    <= '0;
            y     <= '0;
            zHigh <= '0;
            zLow  <= '0;
        end else begin
            if (hiIn) hi <= busData;
            if (loIn) lo <= busData;
            if (yIn)  y  <= busData;
            if (pcIn) begin
                pc <= busData; // jump beats increment
            end else if (incPc) begin
                pc <= pc + 1'b1;
            end
            if (zIn) begin
                zHigh <= aluResult[2*dataWidth-1:dataWidth];
                zLow  <= aluResult[dataWidth-1:0];
            end
        end
    end

    alu #(.dataWidth(dataWidth)) alu0 (
        .a      (y),
        .b      (busData),
        .opcode (opcode),
        .result (aluResult)
    );

    memInterface #(.dataWidth(dataWidth)) mem0 (
        .clk        (clk),
        .rst        (rst),
        .marIn      (marIn),
        .mdrIn      (mdrIn),
        .read       (read),
        .busData    (busData),
        .mdataIn    (mdataIn),
        .inPortData (inPortData),
        .marAddr    (marAddr),
        .mdrVal     (mdrVal),
        .inPortVal  (inPortVal)
    );

    busMux #(.dataWidth(dataWidth)) mux0 (
        .gprDrive  (gprOut),
        .hiOut     (hiOut),
        .loOut     (loOut),
        .zHighOut  (zHighOut),
        .zLowOut   (zLowOut),
        .pcOut     (pcOut),
        .mdrOut    (mdrOut),
        .inPortOut (inPortOut),
        .cOut      (cOut),
        .gprVals   (gprVals),
        .hiVal     (hi),
        .loVal     (lo),
        .zHighVal  (zHigh),
        .zLowVal   (zLow),
        .pcVal     (pc),
        .mdrVal    (mdrVal),
        .inPortVal (inPortVal),
        .cData     (cData),
        .busData   (busData)
    );

endmodule

`default_nettype wire

//--- bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter realtime period = 4.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- bench/datapathTb.sv
`timescale 1ns/1ps
`default_nettype none

module datapathTb;

    localparam int resetCycles = 16;
    localparam int maxGap = 3;
    localparam string testFile = "bench/datapath_tests.txt";

    logic        clk;
    logic        rst;
    logic [15:0] gprIn, gprOut;
    logic        hiIn, loIn, zIn, pcIn, incPc, marIn, mdrIn, yIn, read;
    logic        hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut;
    logic [31:0] cData, mdataIn, inPortData;
    cpuPkg::aluOp opcode;
    wire  [31:0] busData;
    wire  [31:0] marAddr;

    // parsed test lines
    logic [15:0] qGprIn[$], qGprOut[$];
    logic [17:0] qCtrl[$];
    logic [4:0]  qOp[$];
    logic [31:0] qCData[$], qMdata[$], qInPort[$], qExpBus[$], qExpMar[$];
    string       qName[$];

    int errCount = 0;
    int cycles = 0;
    int cycleLimit = 100000;

    clockGen #(.period(4.0)) clk0 (.clk(clk));

    datapath #(.dataWidth(32)) dut0 (
        .clk(clk), .rst(rst), .gprIn(gprIn), .gprOut(gprOut),
        .hiIn(hiIn), .loIn(loIn), .zIn(zIn), .pcIn(pcIn), .incPc(incPc),
        .marIn(marIn), .mdrIn(mdrIn), .yIn(yIn), .read(read),
        .hiOut(hiOut), .loOut(loOut), .zHighOut(zHighOut), .zLowOut(zLowOut),
        .pcOut(pcOut), .mdrOut(mdrOut), .inPortOut(inPortOut), .cOut(cOut),
        .cData(cData), .opcode(opcode), .mdataIn(mdataIn), .inPortData(inPortData),
        .busData(busData), .marAddr(marAddr)
    );

    task automatic finishRun();
        $display("errors: %0d", errCount);
        if (errCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %08h actual %08h", name, expected, actual);
            errCount++;
        end
    endtask

    task automatic readTests(output int ok);
        int    fd;
        int    n;
        string line;
        string nm;
        logic [31:0] v[9];
        ok = 0;
        fd = $fopen(testFile, "r");
        if (fd == 0) begin
            $display("could not open the test data file %s", testFile);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 4 || line.getc(0) == 8'h23) continue; // '#' comment
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %s",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], nm);
            if (n != 10) begin
                $display("malformed line in test data file: %s", line);
                errCount++;
                continue;
            end
            qGprIn.push_back(v[0][15:0]);
            qGprOut.push_back(v[1][15:0]);
            qCtrl.push_back(v[2][17:0]);
            qCData.push_back(v[3]);
            qOp.push_back(v[4][4:0]);
            qMdata.push_back(v[5]);
            qInPort.push_back(v[6]);
            qExpBus.push_back(v[7]);
            qExpMar.push_back(v[8]);
            qName.push_back(nm);
        end
        $fclose(fd);
        ok = 1;
    endtask

    // all strobes low, data inputs hold
    task automatic idleStep();
        gprIn <= '0;
        gprOut <= '0;
        {cOut, inPortOut, mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut} <= '0;
        {read, yIn, mdrIn, marIn, incPc, pcIn, zIn, loIn, hiIn} <= '0;
    endtask

    task automatic applyStep(input int i);
        logic [17:0] c;
        c = qCtrl[i];
        gprIn <= qGprIn[i];
        gprOut <= qGprOut[i];
        {read, yIn, mdrIn, marIn, incPc, pcIn, zIn, loIn, hiIn} <= c[8:0];
        {cOut, inPortOut, mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut} <= c[16:9];
        cData <= qCData[i];
        opcode <= cpuPkg::aluOp'(qOp[i]);
        mdataIn <= qMdata[i];
        inPortData <= qInPort[i];
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles, the run did not complete", cycles);
            errCount++;
            finishRun();
        end
    end

    initial begin
        int ok;
        int gap;
        void'($urandom(4));
        rst = 1'b1;
        gprIn = '0;
        gprOut = '0;
        {read, yIn, mdrIn, marIn, incPc, pcIn, zIn, loIn, hiIn} = '0;
        {cOut, inPortOut, mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut} = '0;
        cData = '0;
        mdataIn = '0;
        inPortData = '0;
        opcode = cpuPkg::opAdd;

        readTests(ok);
        if (ok == 1) begin
            cycleLimit = resetCycles + qName.size() * (maxGap + 1) + 50;
            repeat (resetCycles) @(posedge clk);
            rst <= 1'b0;
            for (int i = 0; i < qName.size(); i++) begin
                gap = int'($urandom_range(0, maxGap));
                repeat (gap) begin
                    @(posedge clk);
                    idleStep();
                end
                @(posedge clk);
                applyStep(i);
                @(negedge clk); // bus settled mid-cycle
                checkValue(qName[i], qExpBus[i], busData);
                if (qCtrl[i][17]) begin
                    checkValue({qName[i], "_mar"}, qExpMar[i], marAddr);
                end
            end
        end else begin
            errCount++;
        end
        finishRun();
    end

endmodule

`default_nettype wire

//--- busDatapath.f
verilog/cpuPkg.sv
verilog/gprFile.sv
verilog/busMux.sv
verilog/alu.sv
verilog/memInterface.sv
verilog/datapath.sv
bench/clockGen.sv
bench/datapathTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f busDatapath.f \
    --top-module datapathTb -o simv

out=$(./obj_dir/simv)
echo "$out"
echo "$out" | grep -qx "TEST RESULT: PASS"

//--- bench/datapath_tests.txt
# gprIn gprOut ctrl cData opcode mdataIn inPortData expBus expMar name
# ctrl from bit 0: hiIn loIn zIn pcIn incPc marIn mdrIn yIn read hiOut loOut zHighOut zLowOut pcOut mdrOut inPortOut cOut chkMar
0000 0080 00000 00000000 0 00000000 00000000 00000000 00000000 rst_r7
0000 0000 00000 00000000 0 00000000 00000000 00000000 00000000 rst_none
0000 0000 02000 00000000 0 00000000 00000000 00000000 00000000 rst_pc
0000 0000 00800 00000000 0 00000000 00000000 00000000 00000000 rst_zhigh
0020 0000 10000 00012345 0 00000000 00000000 00012345 00000000 c_to_r5
0200 0020 00000 00000000 0 00000000 00000000 00012345 00000000 r5_to_r9
0000 0200 00000 00000000 0 00000000 00000000 00012345 00000000 r9_read
0001 0000 10000 0000abcd 0 00000000 00000000 0000abcd 00000000 c_to_r0
0000 0001 00000 00000000 0 00000000 00000000 00000000 00000000 r0_read
0000 0000 10000 0007fff0 0 00000000 00000000 fffffff0 00000000 const_neg
0000 0000 10000 ffe00005 0 00000000 00000000 00000005 00000000 const_trunc
0000 0000 10080 00000064 0 00000000 00000000 00000064 00000000 c_to_y
0000 0000 10004 00000007 0 00000000 00000000 00000007 00000000 add_b
0000 0000 01080 00000000 0 00000000 00000000 0000006b 00000000 add_lo
0000 0000 10004 0007ffff 1 00000000 00000000 ffffffff 00000000 sub_b
0000 0000 01080 00000000 0 00000000 00000000 0000006c 00000000 sub_lo
0000 0000 10004 0000003c 2 00000000 00000000 0000003c 00000000 and_b
0000 0000 01080 00000000 0 00000000 00000000 0000002c 00000000 and_lo
0000 0000 10004 00040003 3 00000000 00000000 fffc0003 00000000 or_b
0000 0000 01080 00000000 0 00000000 00000000 fffc002f 00000000 or_lo
0000 0000 10004 00000004 5 00000000 00000000 00000004 00000000 shra_b
0000 0000 01080 00000000 0 00000000 00000000 ffffc002 00000000 shra_lo
0000 0000 10004 00000024 4 00000000 00000000 00000024 00000000 shr_b
0000 0000 01080 00000000 0 00000000 00000000 0ffffc00 00000000 shr_lo
0000 0000 10004 00000008 6 00000000 00000000 00000008 00000000 shl_b
0000 0000 01080 00000000 0 00000000 00000000 fffc0000 00000000 shl_lo
0000 0000 10004 00000010 7 00000000 00000000 00000010 00000000 ror_b
0000 0000 01080 00000000 0 00000000 00000000 0000fffc 00000000 ror_lo
0000 0000 10004 00000004 8 00000000 00000000 00000004 00000000 rol_b
0000 0000 01080 00000000 0 00000000 00000000 000fffc0 00000000 rol_lo
0000 0000 10004 00000005 b 00000000 00000000 00000005 00000000 neg_b
0000 0000 01000 00000000 0 00000000 00000000 fffffffb 00000000 neg_lo
0000 0000 10004 00012345 c 00000000 00000000 00012345 00000000 not_b
0000 0000 01000 00000000 0 00000000 00000000 fffedcba 00000000 not_lo
0000 0000 00800 00000000 0 00000000 00000000 00000000 00000000 not_hi
0000 0000 10080 0007fffd 0 00000000 00000000 fffffffd 00000000 mul_y
0000 0000 10004 00000007 9 00000000 00000000 00000007 00000000 mul_b
0000 0000 01000 00000000 0 00000000 00000000 ffffffeb 00000000 mul_lo
0000 0000 00800 00000000 0 00000000 00000000 ffffffff 00000000 mul_hi
0000 0000 10080 0007ffe9 0 00000000 00000000 ffffffe9 00000000 div_y
0000 0000 10004 00000005 a 00000000 00000000 00000005 00000000 div_b
0000 0000 01000 00000000 0 00000000 00000000 fffffffc 00000000 div_quot
0000 0000 00800 00000000 0 00000000 00000000 fffffffd 00000000 div_rem
0000 0000 10004 00000000 a 00000000 00000000 00000000 00000000 div0_b
0000 0000 01000 00000000 0 00000000 00000000 ffffffff 00000000 div0_quot
0000 0000 00800 00000000 0 00000000 00000000 ffffffe9 00000000 div0_rem
0000 0000 00140 00000000 0 cafef00d 00000000 00000000 00000000 mdr_read
0000 0000 04000 00000000 0 cafef00d 00000000 cafef00d 00000000 mdr_rd_out
0000 0000 10040 00000123 0 00000000 00000000 00000123 00000000 mdr_bus
0000 0000 04000 00000000 0 00000000 00000000 00000123 00000000 mdr_bus_out
0000 0000 10020 00000456 0 00000000 00000000 00000456 00000000 mar_load
0000 0000 20000 00000000 0 00000000 00000000 00000000 00000456 mar_check
0000 0000 00000 00000000 0 00000000 1234abcd 00000000 00000000 inport_set
0000 0000 08000 00000000 0 00000000 1234abcd 1234abcd 00000000 inport_out
0000 0000 10008 00000100 0 00000000 1234abcd 00000100 00000000 pc_load
0000 0000 02010 00000000 0 00000000 1234abcd 00000100 00000000 pc_inc1
0000 0000 02010 00000000 0 00000000 1234abcd 00000101 00000000 pc_inc2
0000 0000 02000 00000000 0 00000000 1234abcd 00000102 00000000 pc_read
0000 0000 10018 00000200 0 00000000 1234abcd 00000200 00000000 pc_prio
0000 0000 02000 00000000 0 00000000 1234abcd 00000200 00000000 pc_after
0000 0000 10001 00000777 0 00000000 1234abcd 00000777 00000000 hi_load
0000 0000 10200 00000001 0 00000000 1234abcd 00000777 00000000 multi_hi_c
0000 0000 10002 00000abc 0 00000000 1234abcd 00000abc 00000000 lo_load
0000 0000 01400 00000000 0 00000000 1234abcd 00000abc 00000000 multi_lo_z
0000 0001 02000 00000000 0 00000000 1234abcd 00000000 00000000 multi_r0_pc
0000 0020 02000 00000000 0 00000000 1234abcd 00012345 00000000 multi_r5_pc
